// ==== rtl/fir_pkg.sv ====
// Shared types, constants and built-in tap sets for the FIR filter
package fir_pkg;

    // Datapath widths
    typedef logic signed [15:0] sample_t;   // Input and output samples
    typedef logic signed [15:0] coeff_t;    // Q1.15 coefficient
    typedef logic signed [39:0] acc_t;      // Products and sums, guard bits for 256 taps

    // Command port
    typedef logic [1:0] cmd_op_t;
    typedef logic [7:0] tap_addr_t;         // Coefficient index

    localparam cmd_op_t OP_COEFF  = 2'd0;   // Write one coefficient
    localparam cmd_op_t OP_PRESET = 2'd1;   // Load built-in set, data bit 0 picks it
    localparam cmd_op_t OP_CLEAR  = 2'd2;   // Zero the sample history
    // Code 3 is reserved and ignored

    // Fixed-point scaling
    localparam int COEFF_SHIFT = 15;        // Fraction bits of coeff_t

    // Saturation limits of sample_t
    localparam int SAMPLE_MAX = 32767;
    localparam int SAMPLE_MIN = -32768;

    // Built-in tap sets
    localparam int NUM_PRESET_TAPS = 8;

    // Symmetric low-pass, peak in the middle taps
    localparam coeff_t LOWPASS_TAPS [0:NUM_PRESET_TAPS-1] = '{
        16'sh0400,
        16'sh0800,
        16'sh0C00,
        16'sh1000,
        16'sh1000,
        16'sh0C00,
        16'sh0800,
        16'sh0400
    };

    // High-pass, negative outer taps
    localparam coeff_t HIGHPASS_TAPS [0:NUM_PRESET_TAPS-1] = '{
        16'shFC00,
        16'shF800,
        16'sh0400,
        16'sh0800,
        16'sh0800,
        16'sh0400,
        16'shF800,
        16'shFC00
    };

endpackage

// ==== rtl/fir_cmd_decode.sv ====
`timescale 1ns/1ps

// Command decode and coefficient bank
module fir_cmd_decode #(
    parameter int NUM_TAPS = 8
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cmd_valid,
    input  fir_pkg::cmd_op_t                    cmd_op,
    input  fir_pkg::tap_addr_t                  cmd_addr,
    input  fir_pkg::coeff_t                     cmd_data,
    output fir_pkg::coeff_t [NUM_TAPS-1:0]      coeffs,
    output logic                                clear_hist
);

    // Registered command stage
    logic               cmd_valid_q;
    fir_pkg::cmd_op_t   op_q;
    fir_pkg::tap_addr_t addr_q;
    fir_pkg::coeff_t    data_q;

    // Built-in tap for entry idx, zero past the table
    function automatic fir_pkg::coeff_t preset_tap(input logic hp, input int idx);
        fir_pkg::coeff_t tap;
        tap = '0;
        if (idx < fir_pkg::NUM_PRESET_TAPS) begin
            tap = hp ? fir_pkg::HIGHPASS_TAPS[idx[2:0]] : fir_pkg::LOWPASS_TAPS[idx[2:0]];
        end
        return tap;
    endfunction

    // First cycle, capture the command
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_valid_q <= 1'b0;
            clear_hist  <= 1'b0;
        end else begin
            cmd_valid_q <= cmd_valid;
            clear_hist  <= cmd_valid && (cmd_op == fir_pkg::OP_CLEAR); // One-cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            op_q   <= cmd_op;
            addr_q <= cmd_addr;
            data_q <= cmd_data;
        end
    end

    // Second cycle, apply to the bank
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                coeffs[i] <= preset_tap(1'b0, i);           // Low-pass after reset
            end
        end else if (cmd_valid_q) begin
            case (op_q)
                fir_pkg::OP_COEFF: begin
                    if (int'(addr_q) < NUM_TAPS) begin      // Out-of-range address dropped
                        coeffs[addr_q] <= data_q;
                    end
                end
                fir_pkg::OP_PRESET: begin
                    for (int i = 0; i < NUM_TAPS; i++) begin
                        coeffs[i] <= preset_tap(data_q[0], i);
                    end
                end
                default: ;                                  // Clear handled above, code 3 ignored
            endcase
        end
    end

    // Back-to-back clears are not expected from the command source
    a_clear_single: assert property (@(posedge clk) disable iff (!rst_n)
        clear_hist |=> !clear_hist);

endmodule

// ==== rtl/fir_tap_mac.sv ====
`timescale 1ns/1ps

// Tapped delay line with pipelined multiply and sum
module fir_tap_mac #(
    parameter int NUM_TAPS = 8
) (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            sample_valid,
    input  fir_pkg::sample_t                sample_in,
    input  fir_pkg::coeff_t [NUM_TAPS-1:0]  coeffs,
    input  logic                            clear_hist,
    output logic                            sum_valid,
    output fir_pkg::acc_t                   sum
);

    fir_pkg::sample_t delay_line [NUM_TAPS];    // Entry 0 holds the newest sample
    fir_pkg::sample_t line_next  [NUM_TAPS];    // Line contents after this edge
    fir_pkg::acc_t    products   [NUM_TAPS];
    fir_pkg::acc_t    sum_comb;
    logic             prod_valid;               // First valid stage, beside products

    // Next state of the delay line
    always_comb begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            line_next[i] = delay_line[i];       // Hold by default
        end
        if (clear_hist) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                line_next[i] = '0;
            end
        end else if (sample_valid) begin
            line_next[0] = sample_in;
            for (int i = 1; i < NUM_TAPS; i++) begin
                line_next[i] = delay_line[i-1]; // Shift toward older taps
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                delay_line[i] <= '0;
            end
        end else begin
            delay_line <= line_next;
        end
    end

    // Products use the shifted line, so they land on the same edge as the shift
    always_ff @(posedge clk) begin
        if (sample_valid) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                products[i] <= $signed(line_next[i]) * $signed(coeffs[i]); // 40-bit signed
            end
        end
    end

    // Sum of all products
    always_comb begin
        sum_comb = '0;
        for (int i = 0; i < NUM_TAPS; i++) begin
            sum_comb = sum_comb + products[i];
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            sum <= sum_comb;
        end
    end

    // Valid pipeline, two stages
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            sum_valid  <= 1'b0;
        end else begin
            prod_valid <= sample_valid;
            sum_valid  <= prod_valid;
        end
    end

    // Decode must not clear the history while a sample arrives
    a_no_clear_on_sample: assert property (@(posedge clk) disable iff (!rst_n)
        !(clear_hist && sample_valid));

endmodule

// ==== rtl/fir_result.sv ====
`timescale 1ns/1ps

// Output scaling, saturation and clip counter
module fir_result (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sum_valid,
    input  fir_pkg::acc_t       sum,
    output logic                out_valid,
    output fir_pkg::sample_t    out_sample,
    output logic [15:0]         sat_count
);

    fir_pkg::acc_t    scaled;       // Sum with fraction bits removed
    fir_pkg::sample_t clamped;
    logic             clip;

    // Arithmetic shift, rounds toward minus infinity
    assign scaled = sum >>> fir_pkg::COEFF_SHIFT;

    always_comb begin
        clip    = 1'b1;
        clamped = scaled[15:0];
        if (scaled > fir_pkg::acc_t'(fir_pkg::SAMPLE_MAX)) begin
            clamped = fir_pkg::sample_t'(fir_pkg::SAMPLE_MAX);   // Positive overflow
        end else if (scaled < fir_pkg::acc_t'(fir_pkg::SAMPLE_MIN)) begin
            clamped = fir_pkg::sample_t'(fir_pkg::SAMPLE_MIN);   // Negative overflow
        end else begin
            clip = 1'b0;
        end
    end

    // Output register
    always_ff @(posedge clk) begin
        if (sum_valid) begin
            out_sample <= clamped;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sat_count <= '0;
        end else begin
            out_valid <= sum_valid;
            if (sum_valid && clip) begin
                sat_count <= sat_count + 16'd1;                 // Wraps at 2^16
            end
        end
    end

    // A clip count step comes with a full-scale output in the same cycle
    a_clip_full_scale: assert property (@(posedge clk) disable iff (!rst_n)
        (sat_count != $past(sat_count)) |-> (out_valid &&
            (out_sample == fir_pkg::sample_t'(fir_pkg::SAMPLE_MAX) ||
             out_sample == fir_pkg::sample_t'(fir_pkg::SAMPLE_MIN))));

endmodule

// ==== rtl/fir_top.sv ====
`timescale 1ns/1ps

// Programmable FIR filter top level
module fir_top #(
    parameter int NUM_TAPS = 8      // 1 to 256
) (
    input  logic                clk,
    input  logic                rst_n,
    // Sample strobe
    input  logic                sample_valid,
    input  fir_pkg::sample_t    sample_in,
    // Command strobe
    input  logic                cmd_valid,
    input  fir_pkg::cmd_op_t    cmd_op,
    input  fir_pkg::tap_addr_t  cmd_addr,
    input  fir_pkg::coeff_t     cmd_data,
    // Filter output, three cycles after the sample
    output logic                out_valid,
    output fir_pkg::sample_t    out_sample,
    output logic [15:0]         sat_count
);

    fir_pkg::coeff_t [NUM_TAPS-1:0] coeffs;     // Coefficient bank
    logic                           clear_hist;
    logic                           sum_valid;
    fir_pkg::acc_t                  sum;

    fir_cmd_decode #(.NUM_TAPS(NUM_TAPS)) u_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_addr   (cmd_addr),
        .cmd_data   (cmd_data),
        .coeffs     (coeffs),
        .clear_hist (clear_hist)
    );

    fir_tap_mac #(.NUM_TAPS(NUM_TAPS)) u_mac (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample_in    (sample_in),
        .coeffs       (coeffs),
        .clear_hist   (clear_hist),
        .sum_valid    (sum_valid),
        .sum          (sum)
    );

    fir_result u_result (
        .clk        (clk),
        .rst_n      (rst_n),
        .sum_valid  (sum_valid),
        .sum        (sum),
        .out_valid  (out_valid),
        .out_sample (out_sample),
        .sat_count  (sat_count)
    );

endmodule

// ==== test/fir_checker.sv ====
`timescale 1ns/1ps

// Scoreboard with a reference FIR model built from the observed strobes
module fir_checker #(
    parameter int NUM_TAPS = 8
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               sample_valid,
    input  fir_pkg::sample_t   sample_in,
    input  logic               cmd_valid,
    input  fir_pkg::cmd_op_t   cmd_op,
    input  fir_pkg::tap_addr_t cmd_addr,
    input  fir_pkg::coeff_t    cmd_data,
    input  logic               out_valid,
    input  fir_pkg::sample_t   out_sample,
    input  logic [15:0]        sat_count,
    output int                 error_count,
    output int                 pending
);

    fir_pkg::sample_t   hist [NUM_TAPS];    // Model delay line, entry 0 newest
    fir_pkg::coeff_t    bank [NUM_TAPS];    // Model coefficient bank
    logic               cmd_hold;           // Command seen last edge, lands this edge
    fir_pkg::cmd_op_t   op_hold;
    fir_pkg::tap_addr_t addr_hold;
    fir_pkg::coeff_t    data_hold;
    fir_pkg::sample_t   exp_q [$];          // Expected outputs in arrival order
    longint             due_q [$];          // Cycle in which each output must show
    bit                 clip_q [$];         // Output was clamped
    longint             cycle;
    logic [15:0]        sat_model;          // Expected clip count, wraps like the DUT

    // Built-in set entry, zero beyond the eight table taps
    function automatic fir_pkg::coeff_t table_tap(input logic high, input int idx);
        if (idx >= 8) return '0;
        return high ? fir_pkg::HIGHPASS_TAPS[idx] : fir_pkg::LOWPASS_TAPS[idx];
    endfunction

    // Shift in a sample and queue the filter response
    task automatic model_sample(input fir_pkg::sample_t s);
        longint acc;
        longint scaled;
        acc = 0;
        for (int i = NUM_TAPS - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = s;
        for (int i = 0; i < NUM_TAPS; i++) begin
            acc += longint'(hist[i]) * longint'(bank[i]);
        end
        scaled = acc >>> fir_pkg::COEFF_SHIFT;          // Floor of acc / 2^15
        clip_q.push_back(scaled > fir_pkg::SAMPLE_MAX || scaled < fir_pkg::SAMPLE_MIN);
        if (scaled > fir_pkg::SAMPLE_MAX) scaled = fir_pkg::SAMPLE_MAX;
        if (scaled < fir_pkg::SAMPLE_MIN) scaled = fir_pkg::SAMPLE_MIN;
        exp_q.push_back(fir_pkg::sample_t'(scaled));
        due_q.push_back(cycle + 3);                     // Fixed three-cycle latency
    endtask

    task automatic apply_command();
        case (op_hold)
            fir_pkg::OP_COEFF: begin
                if (int'(addr_hold) < NUM_TAPS) bank[addr_hold] = data_hold;
            end
            fir_pkg::OP_PRESET: begin
                for (int i = 0; i < NUM_TAPS; i++) bank[i] = table_tap(data_hold[0], i);
            end
            fir_pkg::OP_CLEAR: begin
                for (int i = 0; i < NUM_TAPS; i++) hist[i] = '0;
            end
            default: ;                                  // Code 3 does nothing
        endcase
    endtask

    // Match out_valid and out_sample against the head of the queue
    task automatic check_output();
        if (!out_valid) begin
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                $display("Output missing at cycle %0d, out_valid stayed low", cycle);
                error_count++;
                exp_q.delete(0);
                due_q.delete(0);
                clip_q.delete(0);
            end
        end else if (exp_q.size() == 0) begin
            $display("out_valid high at cycle %0d with no sample waiting for it", cycle);
            error_count++;
        end else begin
            if (due_q[0] != cycle) begin
                $display("Output at cycle %0d, expected at cycle %0d", cycle, due_q[0]);
                error_count++;
            end
            if (out_sample !== exp_q[0]) begin
                $display("CHECK FAILED out_sample: expected 0x%04h, got 0x%04h",
                         exp_q[0], out_sample);
                error_count++;
            end
            if (clip_q[0]) sat_model = sat_model + 16'd1;
            if (sat_count !== sat_model) begin
                $display("CHECK FAILED sat_count: expected 0x%04h, got 0x%04h",
                         sat_model, sat_count);
                error_count++;
            end
            exp_q.delete(0);
            due_q.delete(0);
            clip_q.delete(0);
        end
    endtask

    initial begin
        error_count = 0;
        pending     = 0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            if (out_valid !== 1'b0 || sat_count !== 16'h0000) begin
                $display("CHECK FAILED reset outputs: out_valid 0x%0h sat_count 0x%04h",
                         out_valid, sat_count);
                error_count++;
            end
            for (int i = 0; i < NUM_TAPS; i++) begin
                hist[i] = '0;
                bank[i] = table_tap(1'b0, i);           // Low-pass after reset
            end
            cmd_hold  = 1'b0;
            sat_model = '0;
            cycle     = 0;
        end else begin
            cycle++;
            check_output();
            if (sample_valid) model_sample(sample_in);  // Uses the bank before this edge
            if (cmd_hold) apply_command();
            cmd_hold  = cmd_valid;
            op_hold   = cmd_op;
            addr_hold = cmd_addr;
            data_hold = cmd_data;
        end
        pending = exp_q.size();
    end

endmodule

// ==== test/fir_tb.sv ====
`timescale 1ns/1ps

// Testbench top, random samples and commands into the FIR filter
module fir_tb;

    localparam int NUM_TAPS   = 8;
    localparam int DRAIN_MAX  = 40;     // Cycles allowed for the pipeline to empty
    localparam int KIND_SMALL = 0;      // Samples within +-2048
    localparam int KIND_FIXED = 1;      // One value repeated
    localparam int KIND_FULL  = 2;      // Any 16-bit value

    logic               clk;
    logic               rst_n;
    logic               sample_valid;
    fir_pkg::sample_t   sample_in;
    logic               cmd_valid;
    fir_pkg::cmd_op_t   cmd_op;
    fir_pkg::tap_addr_t cmd_addr;
    fir_pkg::coeff_t    cmd_data;
    logic               out_valid;
    fir_pkg::sample_t   out_sample;
    logic [15:0]        sat_count;
    int                 chk_errors;
    int                 chk_pending;
    int                 tb_errors;
    integer             seed;
    integer             r;

    always #2 clk = ~clk;               // 4 ns period

    fir_top #(.NUM_TAPS(NUM_TAPS)) dut (
        .clk(clk), .rst_n(rst_n),
        .sample_valid(sample_valid), .sample_in(sample_in),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
        .out_valid(out_valid), .out_sample(out_sample), .sat_count(sat_count)
    );

    fir_checker #(.NUM_TAPS(NUM_TAPS)) u_checker (
        .clk(clk), .rst_n(rst_n),
        .sample_valid(sample_valid), .sample_in(sample_in),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_addr(cmd_addr), .cmd_data(cmd_data),
        .out_valid(out_valid), .out_sample(out_sample), .sat_count(sat_count),
        .error_count(chk_errors), .pending(chk_pending)
    );

    // Step to 1 ns past the next rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        sample_valid = 1'b0;
        cmd_valid    = 1'b0;
        for (int i = 0; i < n; i++) next_cycle();
    endtask

    // Mostly back-to-back strobes, an idle gap now and then
    task automatic send_samples(input int count, input int kind, input fir_pkg::sample_t value);
        integer v;
        for (int i = 0; i < count; i++) begin
            r = $random(seed);
            v = $random(seed);
            if (r[1:0] == 2'b00) begin
                sample_valid = 1'b0;
                next_cycle();
            end
            sample_valid = 1'b1;
            case (kind)
                KIND_SMALL: sample_in = fir_pkg::sample_t'($signed(v[11:0]));
                KIND_FIXED: sample_in = value;
                default:    sample_in = v[15:0];
            endcase
            next_cycle();
        end
        sample_valid = 1'b0;
    endtask

    // Wait until every queued output came back
    task automatic wait_drain();
        int waited;
        waited = 0;
        while (chk_pending != 0 && waited < DRAIN_MAX) begin
            next_cycle();
            waited++;
        end
        if (chk_pending != 0) begin
            $display("Timeout: %0d outputs still pending after %0d cycles", chk_pending,
                     DRAIN_MAX);
            tb_errors++;
        end
    endtask

    // Commands only on a quiet pipeline, then let the bank settle
    task automatic send_command(input fir_pkg::cmd_op_t op, input fir_pkg::tap_addr_t addr,
                                input fir_pkg::coeff_t data);
        wait_drain();
        idle_cycles(4);
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_data  = data;
        next_cycle();
        idle_cycles(3);                 // clear_hist must not meet a sample
    endtask

    initial begin
        seed         = 32'hc85d_384b;
        clk          = 1'b0;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample_in    = '0;
        cmd_valid    = 1'b0;
        cmd_op       = '0;
        cmd_addr     = '0;
        cmd_data     = '0;
        tb_errors    = 0;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;

        send_samples(40, KIND_SMALL, '0);                   // Reset default, low-pass
        send_samples(20, KIND_FULL, '0);
        send_command(fir_pkg::OP_PRESET, 8'd0, 16'sh0001);  // High-pass set
        send_samples(40, KIND_SMALL, '0);

        // Single writes, addresses 8 to 15 fall outside the bank
        for (int i = 0; i < 12; i++) begin
            r = $random(seed);
            send_command(fir_pkg::OP_COEFF, fir_pkg::tap_addr_t'(r[3:0]), r[31:16]);
            send_samples(10, KIND_SMALL, '0);
        end
        send_command(fir_pkg::OP_COEFF, 8'hff, 16'sh7fff);
        send_samples(10, KIND_SMALL, '0);

        // Saturation, both directions
        for (int i = 0; i < NUM_TAPS; i++) begin
            send_command(fir_pkg::OP_COEFF, fir_pkg::tap_addr_t'(i), 16'sh7fff);
        end
        send_samples(12, KIND_FIXED, 16'sh7fff);
        for (int i = 0; i < NUM_TAPS; i++) begin
            send_command(fir_pkg::OP_COEFF, fir_pkg::tap_addr_t'(i), 16'sh8000);
        end
        send_samples(12, KIND_FIXED, 16'sh7fff);

        // History clear and the unused code
        send_command(fir_pkg::OP_PRESET, 8'd0, 16'sh0000);
        send_samples(20, KIND_SMALL, '0);
        send_command(fir_pkg::OP_CLEAR, 8'd0, 16'sh0000);
        send_samples(10, KIND_SMALL, '0);
        send_command(2'd3, 8'd0, 16'sh0001);
        send_samples(10, KIND_SMALL, '0);

        wait_drain();
        idle_cycles(4);
        if (chk_pending != 0) begin
            $display("Expected outputs never arrived, %0d left in the queue", chk_pending);
            tb_errors++;
        end
        $display("Error counts: checker %0d, testbench %0d", chk_errors, tb_errors);
        if (chk_errors == 0 && tb_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/fir_pkg.sv
rtl/fir_cmd_decode.sv
rtl/fir_tap_mac.sv
rtl/fir_result.sv
rtl/fir_top.sv
test/fir_checker.sv
test/fir_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the FIR testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module fir_tb \
    --Mdir obj_dir -o fir_sim \
    && ./obj_dir/fir_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation error"; exit 1; }

cat sim.log
grep -qx "ALL CHECKS PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
